/* include/rename_defs.svh */
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// structure sizes
`define ROB_DEPTH 8
`define NUM_PR    64
`define NUM_ARCH  32

// arch r31 reads as zero, never renamed
`define ZERO_REG  5'd31

// tags left over once every arch reg holds one
`define NUM_FREE  (`NUM_PR - `NUM_ARCH)

`endif

/* src/rename_pkg.sv */
`include "rename_defs.svh"

package rename_pkg;

  typedef logic [$clog2(`NUM_PR)-1:0]    tag_t;       // physical register tag
  typedef logic [$clog2(`NUM_ARCH)-1:0]  arch_idx_t;  // architectural register
  typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;   // reorder buffer slot

  // instruction classes seen by rename
  typedef enum logic [1:0] {
    op_alu,
    op_halt,
    op_illegal
  } op_t;

  // sticky core status
  typedef enum logic [1:0] {
    no_error,
    halted_on_halt,
    halted_on_illegal
  } error_t;

endpackage

/* src/free_list.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module free_list (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             pop,       // new tag taken at dispatch
  input  logic             push,      // old tag handed back at retire
  input  rename_pkg::tag_t push_tag,
  output rename_pkg::tag_t head_tag,
  output logic             fl_ready
);
  import rename_pkg::*;

  localparam int PTR_W = $clog2(`NUM_FREE);

  tag_t             tags [`NUM_FREE];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W:0]   count;   // one extra bit so full and empty differ

  assign head_tag = tags[head];
  assign fl_ready = (count != '0);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      // tags above the arch range start out free, ascending
      for (int i = 0; i < `NUM_FREE; i++) begin
        tags[i] <= tag_t'(`NUM_ARCH + i);
      end
      head  <= '0;
      tail  <= '0;   // full queue, tail wrapped onto head
      count <= (PTR_W + 1)'(`NUM_FREE);
    end else begin
      if (push) begin
        tags[tail] <= push_tag;
        tail       <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;   // next tag visible next cycle
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // both or neither
      endcase
    end
  end

  // the top only pops while fl_ready is high
  a_no_pop_empty: assert property (
    @(posedge clock) disable iff (!rst_n)
    pop |-> (count != '0)
  ) else $error("free list popped while empty");

  // returned tags can never exceed the initial pool
  a_no_push_full: assert property (
    @(posedge clock) disable iff (!rst_n)
    (push && !pop) |-> (count < (PTR_W + 1)'(`NUM_FREE))
  ) else $error("free list pushed while full");

endmodule

/* src/map_table.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module map_table (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  wr_en,     // renaming writer dispatches
  input  rename_pkg::arch_idx_t wr_dest,
  input  rename_pkg::tag_t      wr_tag,
  output rename_pkg::tag_t      old_tag
);
  import rename_pkg::*;

  tag_t map_q [`NUM_ARCH];   // current tag per arch reg

  // lookup of the mapping being replaced, freed later at retire
  assign old_tag = map_q[wr_dest];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_ARCH; i++) begin
        map_q[i] <= tag_t'(i);   // identity after reset
      end
    end else if (wr_en) begin
      map_q[wr_dest] <= wr_tag;
    end
  end

  // zero register keeps tag 31 for good
  a_no_zero_write: assert property (
    @(posedge clock) disable iff (!rst_n)
    wr_en |-> (wr_dest != `ZERO_REG)
  ) else $error("rename of zero register");

  // the same tag must not be handed to two arch regs in a row
  a_new_tag_differs: assert property (
    @(posedge clock) disable iff (!rst_n)
    wr_en |-> (wr_tag != old_tag)
  ) else $error("new tag equals current mapping");

endmodule

/* src/reorder_buffer.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module reorder_buffer (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  dispatch_en,
  input  rename_pkg::op_t       dispatch_op,
  input  rename_pkg::arch_idx_t dispatch_dest,
  input  logic                  dispatch_wr,       // instruction renames its dest
  input  rename_pkg::tag_t      dispatch_tag,
  input  rename_pkg::tag_t      dispatch_old_tag,
  input  logic                  complete_en,
  input  rename_pkg::rob_idx_t  complete_idx,
  input  logic                  stopped,           // core halted, freeze retire
  output logic                  rob_ready,
  output logic                  commit_en,
  output logic                  commit_wr,
  output rename_pkg::arch_idx_t commit_dest,
  output rename_pkg::tag_t      commit_tag,
  output logic                  retire_halt,
  output logic                  retire_illegal,
  output logic                  free_en,
  output rename_pkg::tag_t      free_tag
);
  import rename_pkg::*;

  localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

  // per-slot control bits
  logic [`ROB_DEPTH-1:0] valid_q;
  logic [`ROB_DEPTH-1:0] complete_q;

  // per-slot payload
  op_t       op_q      [`ROB_DEPTH];
  arch_idx_t dest_q    [`ROB_DEPTH];
  logic      wr_q      [`ROB_DEPTH];
  tag_t      tag_q     [`ROB_DEPTH];
  tag_t      old_tag_q [`ROB_DEPTH];

  rob_idx_t   head;
  rob_idx_t   tail;
  logic [CNT_W-1:0] count;
  logic       head_done;   // head finished and allowed to leave
  logic       retire;

  assign rob_ready = (count < CNT_W'(`ROB_DEPTH));

  assign head_done      = valid_q[head] && complete_q[head] && !stopped;
  assign commit_en      = head_done && (op_q[head] == op_alu);
  assign retire_halt    = head_done && (op_q[head] == op_halt);
  assign retire_illegal = head_done && (op_q[head] == op_illegal);
  assign retire         = commit_en || retire_halt || retire_illegal;

  assign commit_wr   = commit_en && wr_q[head];
  assign commit_dest = dest_q[head];
  assign commit_tag  = tag_q[head];

  // previous mapping goes back to the free list
  assign free_en  = commit_wr;
  assign free_tag = old_tag_q[head];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      valid_q    <= '0;
      complete_q <= '0;
      head       <= '0;
      tail       <= '0;
      count      <= '0;
    end else begin
      if (dispatch_en) begin
        valid_q[tail]    <= 1'b1;
        // halt and illegal have nothing to execute
        complete_q[tail] <= (dispatch_op != op_alu);
        tail             <= tail + 1'b1;
      end
      if (complete_en) begin
        complete_q[complete_idx] <= 1'b1;
      end
      if (retire) begin
        valid_q[head]    <= 1'b0;
        complete_q[head] <= 1'b0;
        head             <= head + 1'b1;
      end
      case ({dispatch_en, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch_en) begin
      op_q[tail]      <= dispatch_op;
      dest_q[tail]    <= dispatch_dest;
      wr_q[tail]      <= dispatch_wr;
      tag_q[tail]     <= dispatch_tag;
      old_tag_q[tail] <= dispatch_old_tag;
    end
  end

  // completion strobe must name an in-flight, unfinished slot
  a_complete_legal: assert property (
    @(posedge clock) disable iff (!rst_n)
    complete_en |-> (valid_q[complete_idx] && !complete_q[complete_idx])
  ) else $error("completion of empty or finished slot %0d", complete_idx);

  // dispatch enable from the top honours our ready level
  a_dispatch_room: assert property (
    @(posedge clock) disable iff (!rst_n)
    dispatch_en |-> rob_ready
  ) else $error("dispatch into full reorder buffer");

endmodule

/* src/rename_core.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_core (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  dispatch_valid,
  input  rename_pkg::op_t       dispatch_op,
  input  rename_pkg::arch_idx_t dispatch_dest,
  input  logic                  complete_en,
  input  rename_pkg::rob_idx_t  complete_idx,
  output logic                  dispatch_ready,
  output logic                  commit_en,
  output logic                  commit_wr,
  output rename_pkg::arch_idx_t commit_dest,
  output rename_pkg::tag_t      commit_tag,
  output rename_pkg::error_t    error_status,
  output logic                  stop_cycle
);
  import rename_pkg::*;

  logic   dispatch_en;
  logic   dispatch_wr;
  logic   fl_ready;
  logic   rob_ready;
  tag_t   new_tag;
  tag_t   old_tag;
  logic   retire_halt;
  logic   retire_illegal;
  logic   free_en;
  tag_t   free_tag;
  error_t error_q;

  assign stop_cycle     = (error_q != no_error);
  assign error_status   = error_q;
  assign dispatch_ready = fl_ready && rob_ready && !stop_cycle;
  assign dispatch_en    = dispatch_valid && dispatch_ready;

  // only alu ops to a real register take a tag
  assign dispatch_wr = (dispatch_op == op_alu) && (dispatch_dest != `ZERO_REG);

  // holds the first halting cause until reset
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      error_q <= no_error;
    end else if (retire_halt) begin
      error_q <= halted_on_halt;
    end else if (retire_illegal) begin
      error_q <= halted_on_illegal;
    end
  end

  free_list free_list_0 (
    .clock    (clock),
    .rst_n    (rst_n),
    .pop      (dispatch_en && dispatch_wr),
    .push     (free_en),
    .push_tag (free_tag),
    .head_tag (new_tag),
    .fl_ready (fl_ready)
  );

  map_table map_table_0 (
    .clock   (clock),
    .rst_n   (rst_n),
    .wr_en   (dispatch_en && dispatch_wr),
    .wr_dest (dispatch_dest),
    .wr_tag  (new_tag),
    .old_tag (old_tag)
  );

  reorder_buffer rob_0 (
    .clock            (clock),
    .rst_n            (rst_n),
    .dispatch_en      (dispatch_en),
    .dispatch_op      (dispatch_op),
    .dispatch_dest    (dispatch_dest),
    .dispatch_wr      (dispatch_wr),
    .dispatch_tag     (new_tag),
    .dispatch_old_tag (old_tag),
    .complete_en      (complete_en),
    .complete_idx     (complete_idx),
    .stopped          (stop_cycle),
    .rob_ready        (rob_ready),
    .commit_en        (commit_en),
    .commit_wr        (commit_wr),
    .commit_dest      (commit_dest),
    .commit_tag       (commit_tag),
    .retire_halt      (retire_halt),
    .retire_illegal   (retire_illegal),
    .free_en          (free_en),
    .free_tag         (free_tag)
  );

  // once halted, nothing enters and nothing commits
  a_frozen_when_stopped: assert property (
    @(posedge clock) disable iff (!rst_n)
    stop_cycle |-> (!dispatch_en && !commit_en)
  ) else $error("activity after stop");

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD = 100   // ns
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

endmodule

/* bench/rename_core_tb.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_core_tb;
  import rename_pkg::*;

  localparam string CASE_FILE  = "bench/rename_cases.txt";
  localparam int    WAIT_LIMIT = 200;   // cycles

  typedef struct packed {
    op_t       op;
    arch_idx_t dest;
    logic      wr;
    tag_t      tag;
    tag_t      old_tag;
    rob_idx_t  slot;
  } rob_entry_t;

  logic      clock;
  logic      rst_n;
  logic      dispatch_valid;
  op_t       dispatch_op;
  arch_idx_t dispatch_dest;
  logic      complete_en;
  rob_idx_t  complete_idx;
  logic      dispatch_ready;
  logic      commit_en;
  logic      commit_wr;
  arch_idx_t commit_dest;
  tag_t      commit_tag;
  error_t    error_status;
  logic      stop_cycle;

  // reference model state
  tag_t       map_m [`NUM_ARCH];
  tag_t       free_q [$];
  rob_entry_t rob_q [$];           // in flight, oldest first
  logic       done_m [`ROB_DEPTH];
  rob_idx_t   tail_m;
  logic       stopped_m;
  error_t     err_m;
  int         drv_slot;            // dispatches sent since reset
  int         write_commits;
  int         stops_seen;

  tb_clock clk0 (.clock(clock));

  rename_core dut0 (
    .clock          (clock),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch_op    (dispatch_op),
    .dispatch_dest  (dispatch_dest),
    .complete_en    (complete_en),
    .complete_idx   (complete_idx),
    .dispatch_ready (dispatch_ready),
    .commit_en      (commit_en),
    .commit_wr      (commit_wr),
    .commit_dest    (commit_dest),
    .commit_tag     (commit_tag),
    .error_status   (error_status),
    .stop_cycle     (stop_cycle)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_idx(input string name, input arch_idx_t got, input arch_idx_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_error(input string name, input error_t got, input error_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // identity map, tags 32..63 free, empty rob
  task automatic model_init();
    free_q.delete();
    rob_q.delete();
    for (int i = 0; i < `NUM_ARCH; i++) begin
      map_m[i] = tag_t'(i);
    end
    for (int i = `NUM_ARCH; i < `NUM_PR; i++) begin
      free_q.push_back(tag_t'(i));
    end
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      done_m[i] = 1'b0;
    end
    tail_m    = '0;
    stopped_m = 1'b0;
    err_m     = no_error;
    drv_slot  = 0;
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;   // drive just after the edge
  endtask

  task automatic reset_dut();
    next_cycle();
    rst_n          = 1'b0;
    dispatch_valid = 1'b0;
    complete_en    = 1'b0;
    model_init();
    repeat (5) @(posedge clock);
    #1;
    rst_n = 1'b1;
  endtask

  // hold dispatch_valid until the core takes it
  task automatic accept_dispatch();
    int waited;
    waited = 0;
    @(negedge clock);
    while (!dispatch_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("timeout waiting for dispatch_ready");
      end else begin
        @(negedge clock);
      end
    end
    next_cycle();
    dispatch_valid = 1'b0;
    drv_slot++;
  endtask

  task automatic send_dispatch(input op_t op, input arch_idx_t dest);
    dispatch_valid = 1'b1;
    dispatch_op    = op;
    dispatch_dest  = dest;
    accept_dispatch();
  endtask

  task automatic send_complete(input rob_idx_t slot);
    complete_en  = 1'b1;
    complete_idx = slot;
    next_cycle();
    complete_en = 1'b0;
  endtask

  // instruction waits on a full rob while the head slot finishes
  task automatic held_dispatch(input rob_idx_t slot, input arch_idx_t dest);
    dispatch_valid = 1'b1;
    dispatch_op    = op_alu;
    dispatch_dest  = dest;
    @(negedge clock);
    check_bit("dispatch_ready", dispatch_ready, 1'b0);
    next_cycle();
    send_complete(slot);
    accept_dispatch();
  endtask

  task automatic run_burst(input int n, input int dest);
    arch_idx_t d;
    for (int i = 0; i < n; i++) begin
      d = arch_idx_t'((dest + i) % (`NUM_ARCH - 1));   // stays below r31
      send_dispatch(op_alu, d);
      send_complete(rob_idx_t'(drv_slot - 1));
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (rob_q.size() != 0) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("timeout waiting for the reorder buffer to drain");
      end else begin
        next_cycle();
      end
    end
  endtask

  task automatic wait_stop();
    int waited;
    waited = 0;
    while (!stop_cycle) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("timeout waiting for stop_cycle");
      end else begin
        next_cycle();
      end
    end
  endtask

  // mid-cycle compare, then model the coming edge
  always @(negedge clock) begin : monitor
    logic       exp_ready;
    logic       head_retires;
    logic       exp_commit;
    rob_entry_t ent;
    if (rst_n) begin
      exp_ready    = (free_q.size() != 0) && (rob_q.size() < `ROB_DEPTH) && !stopped_m;
      head_retires = !stopped_m && (rob_q.size() != 0) && done_m[rob_q[0].slot];
      exp_commit   = head_retires && (rob_q[0].op == op_alu);
      check_bit("stop_cycle", stop_cycle, stopped_m);
      check_error("error_status", error_status, err_m);
      check_bit("dispatch_ready", dispatch_ready, exp_ready);
      check_bit("commit_en", commit_en, exp_commit);
      if (exp_commit) begin
        check_idx("commit_dest", commit_dest, rob_q[0].dest);
        check_bit("commit_wr", commit_wr, rob_q[0].wr);
        if (rob_q[0].wr) begin
          check_tag("commit_tag", commit_tag, rob_q[0].tag);
        end
      end
      if (head_retires) begin
        ent = rob_q.pop_front();
        done_m[ent.slot] = 1'b0;
        if (ent.wr) begin
          free_q.push_back(ent.old_tag);   // old mapping freed
          write_commits++;
        end
        if (ent.op == op_halt) begin
          err_m     = halted_on_halt;
          stopped_m = 1'b1;
          stops_seen++;
        end else if (ent.op == op_illegal) begin
          err_m     = halted_on_illegal;
          stopped_m = 1'b1;
          stops_seen++;
        end
      end
      if (complete_en) begin
        done_m[complete_idx] = 1'b1;
      end
      if (dispatch_valid && exp_ready) begin
        ent.op      = dispatch_op;
        ent.dest    = dispatch_dest;
        ent.wr      = (dispatch_op == op_alu) && (dispatch_dest != `ZERO_REG);
        ent.slot    = tail_m;
        ent.tag     = '0;
        ent.old_tag = '0;
        if (ent.wr) begin
          ent.tag         = free_q.pop_front();
          ent.old_tag     = map_m[ent.dest];
          map_m[ent.dest] = ent.tag;
        end
        done_m[tail_m] = (dispatch_op != op_alu);   // halt, illegal done at once
        rob_q.push_back(ent);
        tail_m = tail_m + 1'b1;
      end
    end
  end

  initial begin : stimulus
    int    fd;
    string line;
    byte   cmd;
    int    arg0;
    int    arg1;
    rst_n          = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_op    = op_alu;
    dispatch_dest  = '0;
    complete_en    = 1'b0;
    complete_idx   = '0;
    write_commits  = 0;
    stops_seen     = 0;
    model_init();
    reset_dut();
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      abort_run("cannot open the case file");
    end
    while ($fgets(line, fd) != 0) begin
      cmd  = line.getc(0);
      arg0 = 0;
      arg1 = 0;
      if (line.len() > 1) begin
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h", arg0, arg1));
      end
      case (cmd)
        "#", " ", "\n", "\r", 8'h00: ;   // comment or blank line
        "A":     send_dispatch(op_alu, arch_idx_t'(arg0));
        "H":     send_dispatch(op_halt, '0);
        "I":     send_dispatch(op_illegal, '0);
        "C":     send_complete(rob_idx_t'(arg0));
        "B":     held_dispatch(rob_idx_t'(arg0), arch_idx_t'(arg1));
        "T":     run_burst(arg0, arg1);
        "W":     wait_drain();
        "S":     wait_stop();
        "N":     repeat (arg0) next_cycle();
        "R":     reset_dut();
        default: abort_run("unknown command in the case file");
      endcase
    end
    $fclose(fd);
    if (write_commits > `NUM_FREE && stops_seen > 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      abort_run("case file ended before tag reuse and a halt were covered");
    end
  end

endmodule

/* flist.f */
+incdir+include
src/rename_pkg.sv
src/free_list.sv
src/map_table.sv
src/reorder_buffer.sv
src/rename_core.sv
bench/tb_clock.sv
bench/rename_core_tb.sv

/* Makefile */
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
TOP        = rename_core_tb
RTL_TOP    = rename_core
FLIST      = flist.f
PASS_MSG   = TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* bench/rename_cases.txt */
# one command per line, arguments in hex
# A dest: alu op, H: halt, I: illegal, C slot: complete rob slot
# B slot dest: alu op held under back-pressure while slot completes
# T n dest: n alu ops from dest upward, each completed at once
# W: wait for empty rob, S: wait for stop, N n: idle cycles, R: reset
A 01
A 02
A 01
A 1f
A 05
C 2
C 4
C 0
C 3
C 1
W
A 03
A 04
A 1f
A 06
A 07
A 08
A 09
A 0a
B 5 0b
C 6
C 7
C 0
C 1
C 2
C 3
C 4
C 5
W
T 28 00
A 1f
C 6
W
A 0c
H
A 0d
C 7
C 1
S
N 4
R
A 02
I
C 0
S
N 4
